/* axi_burst_adapter_wr.f */
+incdir+source
source/axi_wr_pkg.sv
source/burst_addr_gen.sv
source/wdata_path.sv
source/resp_merge.sv
source/axi_burst_adapter_wr.sv
tb/tb_clk_gen.sv
tb/axi_burst_adapter_wr_props.sv
tb/axi_burst_adapter_wr_tb.sv

/* source/axi_burst_adapter_wr.sv */
`timescale 1ns/1ps

module axi_burst_adapter_wr (
  input  logic            clk,
  input  logic            rst_n,
  input  axi_wr_pkg::aw_t s_aw,
  input  logic            s_awvalid,
  output logic            s_awready,
  input  axi_wr_pkg::w_t  s_w,
  input  logic            s_wvalid,
  output logic            s_wready,
  output axi_wr_pkg::b_t  s_b,
  output logic            s_bvalid,
  input  logic            s_bready,
  output axi_wr_pkg::aw_t m_aw,
  output logic            m_awvalid,
  input  logic            m_awready,
  output axi_wr_pkg::w_t  m_w,
  output logic            m_wvalid,
  input  logic            m_wready,
  input  axi_wr_pkg::b_t  m_b,
  input  logic            m_bvalid,
  output logic            m_bready
);
  import axi_wr_pkg::*;

  logic      issue_pulse; // one per downstream address.
  logic      out_full;
  logic      burst_done;
  logic      start_valid;
  id_t       start_id;
  beat_cnt_t start_beats;

  burst_addr_gen u_addr_gen (
    .clk(clk), .rst_n(rst_n),
    .s_aw(s_aw), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .out_full(out_full), .burst_done(burst_done), .issue_pulse(issue_pulse),
    .start_valid(start_valid), .start_id(start_id), .start_beats(start_beats)
  );

  wdata_path u_wdata (
    .clk(clk), .rst_n(rst_n), .issue_pulse(issue_pulse),
    .s_w(s_w), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready)
  );

  resp_merge u_resp (
    .clk(clk), .rst_n(rst_n),
    .start_valid(start_valid), .start_id(start_id), .start_beats(start_beats),
    .issue_pulse(issue_pulse), .out_full(out_full),
    .m_b(m_b), .m_bvalid(m_bvalid), .m_bready(m_bready),
    .s_b(s_b), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .burst_done(burst_done)
  );

endmodule

/* source/axi_wr_pkg.sv */
`include "axi_wr_settings.svh"

package axi_wr_pkg;

  // ************************************************************
  // width types
  // ************************************************************

  typedef logic [`AXI_WR_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_WR_DATA_W-1:0]   data_t;
  typedef logic [`AXI_WR_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_WR_ID_W-1:0]     id_t;

  typedef logic [7:0] len_t;      // beats minus one.
  typedef logic [2:0] size_t;     // log2 of bytes per beat.
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;
  typedef logic [8:0] beat_cnt_t; // holds 256.

  localparam burst_t burst_fixed = 2'b00;
  localparam resp_t  resp_okay   = 2'b00;

  // ************************************************************
  // channel payloads
  // ************************************************************

  typedef struct packed {
    addr_t  addr;
    id_t    id;
    len_t   len;
    size_t  size;
    burst_t burst;
  } aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_t;

  // address sequencer states.
  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait_resp
  } addr_state_t;

endpackage

/* source/axi_wr_settings.svh */
`ifndef AXI_WR_SETTINGS_SVH
`define AXI_WR_SETTINGS_SVH

// ************************************************************
// bus widths
// ************************************************************

`define AXI_WR_ADDR_W 20 // byte address.
`define AXI_WR_DATA_W 16
`define AXI_WR_ID_W   4

// ************************************************************
// downstream limits
// ************************************************************

// single-beat writes that may wait for a response at once.
`define AXI_WR_MAX_OUT 4

`endif

/* source/burst_addr_gen.sv */
`timescale 1ns/1ps

module burst_addr_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi_wr_pkg::aw_t       s_aw,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  output axi_wr_pkg::aw_t       m_aw,
  output logic                  m_awvalid,
  input  logic                  m_awready,
  input  logic                  out_full,
  input  logic                  burst_done,
  output logic                  issue_pulse,
  output logic                  start_valid,
  output axi_wr_pkg::id_t       start_id,
  output axi_wr_pkg::beat_cnt_t start_beats
);
  import axi_wr_pkg::*;

  addr_state_t state_q;
  addr_state_t state_d;
  aw_t         burst_q;    // accepted burst.
  beat_cnt_t   issued_q;   // beats issued so far.
  addr_t       beat_offset;
  logic        aw_accept;
  logic        last_issue;

  assign s_awready = (state_q == st_idle);
  assign aw_accept = s_awvalid && s_awready;

  // out_full can only fall while a request waits, so valid stays up.
  assign m_awvalid   = (state_q == st_issue) && !out_full;
  assign issue_pulse = m_awvalid && m_awready;
  assign last_issue  = (issued_q == beat_cnt_t'(burst_q.len));

  assign start_valid = aw_accept;
  assign start_id    = s_aw.id;
  assign start_beats = beat_cnt_t'(s_aw.len) + beat_cnt_t'(1);

  // ************************************************************
  // beat address
  // ************************************************************

  always_comb begin
    if (burst_q.burst == burst_fixed) begin
      beat_offset = '0;
    end else begin
      beat_offset = addr_t'(issued_q) << burst_q.size; // incr step.
    end
    m_aw      = burst_q;
    m_aw.addr = burst_q.addr + beat_offset;
    m_aw.len  = '0; // one beat per request.
  end

  // ************************************************************
  // sequencer
  // ************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (aw_accept) state_d = st_issue;
      end
      st_issue: begin
        if (issue_pulse && last_issue) state_d = st_wait_resp;
      end
      st_wait_resp: begin
        if (burst_done) state_d = st_idle; // merged response taken.
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= st_idle;
      issued_q <= '0;
    end else begin
      state_q <= state_d;
      if (aw_accept) begin
        issued_q <= '0;
      end else if (issue_pulse) begin
        issued_q <= issued_q + beat_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_accept) burst_q <= s_aw;
  end

endmodule

/* source/resp_merge.sv */
`timescale 1ns/1ps

`include "axi_wr_settings.svh"

module resp_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_valid,
  input  axi_wr_pkg::id_t       start_id,
  input  axi_wr_pkg::beat_cnt_t start_beats,
  input  logic                  issue_pulse,
  output logic                  out_full,
  input  axi_wr_pkg::b_t        m_b,
  input  logic                  m_bvalid,
  output logic                  m_bready,
  output axi_wr_pkg::b_t        s_b,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  output logic                  burst_done
);
  import axi_wr_pkg::*;

  id_t       id_q;
  beat_cnt_t beats_q;  // responses expected.
  beat_cnt_t rcv_q;    // responses seen.
  beat_cnt_t out_q;    // beats waiting downstream.
  resp_t     worst_q;
  logic      b_fire;
  logic      final_resp;

  assign m_bready   = 1'b1;
  assign b_fire     = m_bvalid && m_bready;
  assign final_resp = b_fire && ((rcv_q + beat_cnt_t'(1)) == beats_q);
  assign out_full   = (out_q == beat_cnt_t'(`AXI_WR_MAX_OUT));
  assign burst_done = s_bvalid && s_bready;

  assign s_b = '{id: id_q, resp: worst_q};

  // ************************************************************
  // outstanding beats
  // ************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q <= '0;
    end else begin
      case ({issue_pulse, b_fire})
        2'b10:   out_q <= out_q + beat_cnt_t'(1);
        2'b01:   out_q <= out_q - beat_cnt_t'(1);
        default: out_q <= out_q;
      endcase
    end
  end

  // ************************************************************
  // response collection
  // ************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rcv_q    <= '0;
      s_bvalid <= 1'b0;
    end else begin
      if (start_valid) begin
        rcv_q <= '0;
      end else if (b_fire) begin
        rcv_q <= rcv_q + beat_cnt_t'(1);
      end
      if (final_resp) begin
        s_bvalid <= 1'b1;
      end else if (burst_done) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  // higher codes are worse, so the merge keeps the maximum.
  always_ff @(posedge clk) begin
    if (start_valid) begin
      id_q    <= start_id;
      beats_q <= start_beats;
      worst_q <= resp_okay;
    end else if (b_fire && (m_b.resp > worst_q)) begin
      worst_q <= m_b.resp;
    end
  end

endmodule

/* source/wdata_path.sv */
`timescale 1ns/1ps

module wdata_path (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           issue_pulse,
  input  axi_wr_pkg::w_t s_w,
  input  logic           s_wvalid,
  output logic           s_wready,
  output axi_wr_pkg::w_t m_w,
  output logic           m_wvalid,
  input  logic           m_wready
);
  import axi_wr_pkg::*;

  beat_cnt_t credit_q; // addresses issued but not yet matched by a beat.
  logic      have_credit;
  logic      w_fire;

  assign have_credit = (credit_q != '0);

  // ************************************************************
  // beat forwarding
  // ************************************************************

  // a beat only passes once its address is on the bus.
  assign m_wvalid = s_wvalid && have_credit;
  assign s_wready = m_wready && have_credit;
  assign w_fire   = m_wvalid && m_wready;

  always_comb begin
    m_w      = s_w;
    m_w.last = 1'b1; // every downstream write is a single beat.
  end

  // ************************************************************
  // credit counter
  // ************************************************************

  // the count is bounded by the outstanding limit, since a response
  // never arrives before its data beat.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_q <= '0;
    end else begin
      case ({issue_pulse, w_fire})
        2'b10: begin
          credit_q <= credit_q + beat_cnt_t'(1);
        end
        2'b01: begin
          credit_q <= credit_q - beat_cnt_t'(1);
        end
        default: begin
          credit_q <= credit_q; // none or both.
        end
      endcase
    end
  end

endmodule

/* tb/axi_burst_adapter_wr_props.sv */
`timescale 1ns/1ps

module axi_burst_adapter_wr_props (
  input logic            clk,
  input logic            rst_n,
  input axi_wr_pkg::aw_t m_aw,
  input logic            m_awvalid,
  input logic            m_awready,
  input axi_wr_pkg::w_t  m_w,
  input logic            m_wvalid,
  input logic            m_wready,
  input axi_wr_pkg::b_t  s_b,
  input logic            s_bvalid,
  input logic            s_bready
);
  import axi_wr_pkg::*;

  int fail_cnt = 0; // property failures so far.

  // ************************************************************
  // valid holds its payload until ready
  // ************************************************************

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw))
    else begin
      fail_cnt++;
      $error("m_aw request dropped or changed before m_awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid && !m_wready |=> m_wvalid && $stable(m_w))
    else begin
      fail_cnt++;
      $error("m_w beat dropped or changed before m_wready");
    end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_b))
    else begin
      fail_cnt++;
      $error("s_b response dropped or changed before s_bready");
    end

  // ************************************************************
  // every downstream write is a single beat
  // ************************************************************

  aw_single: assert property (@(posedge clk) disable iff (!rst_n)
    m_awvalid |-> m_aw.len == len_t'(0))
    else begin
      fail_cnt++;
      $error("m_aw carries a nonzero len");
    end

  w_single: assert property (@(posedge clk) disable iff (!rst_n)
    m_wvalid |-> m_w.last)
    else begin
      fail_cnt++;
      $error("m_w beat without last");
    end

endmodule

/* tb/axi_burst_adapter_wr_stim.txt */
# B addr id len size burst merged_bresp   (one burst, every field in hex)
# D data strb bresp                       (one beat of that burst, downstream bresp)
B 01000 3 00 1 1 0
D a5c3 3 0
B 02004 5 03 1 1 1
D 1111 3 0
D 2222 3 1
D 3333 1 0
D 4444 2 0
B 03010 a 02 1 0 2
D 0f0f 3 0
D f0f0 3 2
D 00ff 3 0
B 04001 7 05 0 1 3
D aa00 2 1
D 00bb 1 0
D cc00 2 3
D 00dd 1 2
D ee00 2 0
D 0011 1 1
B 05000 c 07 1 1 0
D 8001 3 0
D 8002 3 0
D 8003 3 0
D 8004 3 0
D 8005 3 0
D 8006 3 0
D 8007 3 0
D 8008 3 0

/* tb/axi_burst_adapter_wr_tb.sv */
`timescale 1ns/1ps

`include "axi_wr_settings.svh"

module axi_burst_adapter_wr_tb;
  import axi_wr_pkg::*;

  logic  clk;
  logic  rst_n;
  aw_t   s_aw = '0;
  logic  s_awvalid = 1'b0;
  logic  s_awready;
  w_t    s_w = '0;
  logic  s_wvalid = 1'b0;
  logic  s_wready;
  b_t    s_b;
  logic  s_bvalid;
  logic  s_bready = 1'b0;
  aw_t   m_aw;
  logic  m_awvalid;
  logic  m_awready = 1'b0;
  w_t    m_w;
  logic  m_wvalid;
  logic  m_wready = 1'b0;
  b_t    m_b = '0;
  logic  m_bvalid = 1'b0;
  logic  m_bready;

  aw_t   burst_aw[$];  // upstream bursts, in file order.
  resp_t burst_exp[$];
  int    burst_end[$]; // beat index just past each burst.
  aw_t   beat_aw[$];   // expected downstream request per beat.
  w_t    beat_w[$];
  resp_t beat_resp[$];

  int          aw_cnt = 0;
  int          w_cnt = 0;
  int          b_cnt = 0;
  int          b_raised = 0;
  int          aw_taken = 0;
  int          up_b_cnt = 0;
  int          value_errs = 0;
  int          order_errs = 0;
  logic        stim_ok = 1'b0;
  logic        offer;
  string       stim_problem = "";
  logic [31:0] lfsr_state = 32'h3b7;

  tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  axi_burst_adapter_wr dut (.*);

  bind axi_burst_adapter_wr axi_burst_adapter_wr_props u_props (
    .clk(clk), .rst_n(rst_n), .m_aw(m_aw), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_w(m_w), .m_wvalid(m_wvalid), .m_wready(m_wready),
    .s_b(s_b), .s_bvalid(s_bvalid), .s_bready(s_bready)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic log_mismatch(input string msg);
    value_errs++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic log_order(input string msg);
    order_errs++;
    $display("ordering broken at %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string why);
    $display("run stopped: %s", why);
    $display("closing counts: value errors %0d, ordering errors %0d, property errors %0d",
             value_errs, order_errs, dut.u_props.fail_cnt);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // ************************************************************
  // stim file
  // ************************************************************

  task automatic load_stim();
    int          fd;
    int          pending;
    int          n;
    string       line;
    logic [31:0] f[6];
    aw_t         aw;
    resp_t       worst;
    pending = 0;
    worst   = resp_okay;
    fd = $fopen("tb/axi_burst_adapter_wr_stim.txt", "r");
    if (fd == 0) begin
      stim_problem = "cannot open tb/axi_burst_adapter_wr_stim.txt";
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      if (line[0] == "B") begin
        if ($sscanf(line, "B %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5]) != 6 || pending != 0)
          stim_problem = "bad burst record in stim file";
        aw = '{addr: addr_t'(f[0]), id: id_t'(f[1]), len: len_t'(f[2]),
               size: size_t'(f[3]), burst: burst_t'(f[4])};
        burst_aw.push_back(aw);
        burst_exp.push_back(resp_t'(f[5]));
        pending = int'(aw.len) + 1;
        worst   = resp_okay;
      end else if (line[0] == "D") begin
        if ($sscanf(line, "D %h %h %h", f[0], f[1], f[2]) != 3 || pending == 0)
          stim_problem = "bad beat record in stim file";
        aw = burst_aw[$];
        n  = int'(aw.len) + 1 - pending; // beat number inside the burst.
        if (aw.burst != burst_fixed) aw.addr = aw.addr + (addr_t'(n) << aw.size);
        aw.len = '0;
        pending--;
        beat_aw.push_back(aw);
        beat_w.push_back('{data: data_t'(f[0]), strb: strb_t'(f[1]), last: pending == 0});
        beat_resp.push_back(resp_t'(f[2]));
        if (resp_t'(f[2]) > worst) worst = resp_t'(f[2]);
        if (pending == 0) begin
          burst_end.push_back(beat_aw.size());
          if (worst != burst_exp[$]) stim_problem = "merged bresp in stim file is not the worst";
        end
      end
    end
    $fclose(fd);
    if (pending != 0) stim_problem = "stim file ends inside a burst";
  endtask

  // ************************************************************
  // manager side
  // ************************************************************

  task automatic drive_aw_channel();
    foreach (burst_aw[i]) begin
      s_aw      <= burst_aw[i];
      s_awvalid <= 1'b1;
      @(posedge clk);
      while (!s_awready) @(posedge clk);
    end
    s_awvalid <= 1'b0;
  endtask

  task automatic drive_w_channel();
    foreach (beat_w[i]) begin
      s_w      <= beat_w[i];
      s_wvalid <= 1'b1;
      @(posedge clk);
      while (!s_wready) @(posedge clk);
    end
    s_wvalid <= 1'b0;
  endtask

  // ************************************************************
  // downstream subordinate and monitors
  // ************************************************************

  always @(posedge clk) begin
    if (rst_n) begin
      // one burst open at a time.
      assert (s_awready == (aw_taken == up_b_cnt))
        else log_mismatch($sformatf("s_awready %b with %0d bursts open", s_awready,
                                    aw_taken - up_b_cnt));
      if (s_awvalid && s_awready) aw_taken++;
      if (s_wvalid) begin
        assert (s_wready == (m_wvalid && m_wready))
          else log_mismatch($sformatf("s_wready %b but downstream beat taken %b", s_wready,
                                      m_wvalid && m_wready));
      end
      if (m_bvalid) begin
        assert (m_bready) else log_mismatch("m_bready low while a response is offered");
        b_cnt++;
      end
      if (m_wvalid && m_wready) begin
        assert (w_cnt < aw_cnt) else log_order($sformatf("beat %0d before its address", w_cnt));
        assert (w_cnt < beat_w.size() && m_w == w_t'{data: beat_w[w_cnt].data,
                                                     strb: beat_w[w_cnt].strb, last: 1'b1})
          else log_mismatch($sformatf("w beat %0d got %h/%h exp %h/%h", w_cnt, m_w.data,
                                      m_w.strb, beat_w[w_cnt].data, beat_w[w_cnt].strb));
        w_cnt++;
      end
      if (m_awvalid && m_awready) begin
        assert (aw_cnt < beat_aw.size() && m_aw == beat_aw[aw_cnt])
          else log_mismatch($sformatf("aw beat %0d got addr %h exp %h", aw_cnt, m_aw.addr,
                                      beat_aw[aw_cnt].addr));
        aw_cnt++;
      end
      assert (aw_cnt - b_cnt <= `AXI_WR_MAX_OUT)
        else log_order($sformatf("%0d beats outstanding downstream", aw_cnt - b_cnt));
      if (s_bvalid && s_bready) begin
        assert (up_b_cnt < burst_aw.size()) else log_order("upstream response with no burst");
        assert (s_b == b_t'{id: burst_aw[up_b_cnt].id, resp: burst_exp[up_b_cnt]}
                && b_cnt == burst_end[up_b_cnt])
          else log_mismatch($sformatf("burst %0d response id %h resp %h after %0d beats",
                                      up_b_cnt, s_b.id, s_b.resp, b_cnt));
        up_b_cnt++;
      end
      m_awready <= rand_bit();
      m_wready  <= rand_bit();
      s_bready  <= rand_bit();
      offer = rand_bit() & rand_bit(); // responses come slowly so the limit is reached.
      if (offer && b_raised < aw_cnt && b_raised < w_cnt) begin
        m_b      <= '{id: beat_aw[b_raised].id, resp: beat_resp[b_raised]};
        m_bvalid <= 1'b1;
        b_raised++;
      end else begin
        m_bvalid <= 1'b0;
      end
    end
  end

  initial begin
    wait (stim_ok);
    repeat (beat_aw.size() * 40 + 1000) @(posedge clk);
    abort_run("watchdog expired before the last burst response");
  end

  initial begin
    load_stim();
    if (stim_problem != "") begin
      abort_run(stim_problem);
    end else begin
      stim_ok = 1'b1;
      wait (rst_n);
      @(posedge clk);
      assert (!m_awvalid && !m_wvalid && !s_bvalid && s_awready)
        else log_mismatch("handshake outputs not idle after reset");
      fork
        drive_aw_channel();
        drive_w_channel();
      join_none
      wait (up_b_cnt == burst_aw.size());
      repeat (20) @(posedge clk); // window for a stray response.
      assert (aw_cnt == beat_aw.size() && w_cnt == beat_w.size() && b_cnt == beat_aw.size())
        else log_mismatch($sformatf("downstream saw aw %0d w %0d b %0d", aw_cnt, w_cnt, b_cnt));
      $display("closing counts: value errors %0d, ordering errors %0d, property errors %0d",
               value_errs, order_errs, dut.u_props.fail_cnt);
      if (value_errs + order_errs + dut.u_props.fail_cnt == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period.
  end

  // reset held over the first 16 rising edges.
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule
